//--- build.f
+incdir+include
src/ldq_pkg.sv
src/ldq_ptr.sv
src/ldq_entry.sv
src/ldq_haz_check.sv
src/ldq_top.sv
test/tb_clk_gen.sv
test/tb_ldq_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the load queue testbench with Verilator.
# Exit status is 0 only when the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f build.f \
  --top-module tb_ldq_top \
  -o sim_ldq \
  && ./obj_dir/sim_ldq | tee /dev/stderr | grep -q "^TEST PASS$" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- test/tb_ldq_top.sv
// Load queue testbench; the cycle model assumes two load pipes, two store pipes and eight entries
`default_nettype none
`timescale 1ns/100ps

`include "ldq_cfg.svh"

module tb_ldq_top;

  import ldq_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int TEST_CYCLES = 700;

  logic         i_clk;
  logic         i_reset_n;
  logic [1:0]   disp_valid;
  ldq_disp_t    disp     [2];
  ldq_upd_t     upd      [2];
  ldq_resolve_t resolve;
  ldq_commit_t  commit;
  ldq_haz_req_t haz_req  [2];
  logic         ret_valid;
  ldq_haz_rsp_t haz_rsp  [2];

  // Queue model with one slot per entry
  logic       m_valid [8];
  logic       m_dead  [8];
  logic       m_cmtd  [8];
  ldq_state_e m_state [8];
  logic [4:0] m_id    [8];
  logic [31:0] m_addr [8];
  logic [1:0] m_size  [8];
  logic [1:0] m_midx  [8];
  int         m_in;
  int         m_out;
  logic       exp_ret;
  logic       exp_hv  [2];
  logic [4:0] exp_hid [2];

  logic [31:0] lfsr;
  logic [4:0]  next_id;
  logic        probe_en;
  int          credits;
  int          n_disp;
  int          n_ret;
  int          n_check_err;
  int          n_other_err;
  logic [4:0]  exec_q[$];

  tb_clk_gen #(.CLK_PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clk_gen (
    .o_clk     (i_clk),
    .o_reset_n (i_reset_n)
  );

  ldq_top ldq_top_inst (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (disp_valid),
    .i_disp       (disp),
    .i_upd        (upd),
    .i_resolve    (resolve),
    .i_commit     (commit),
    .i_haz_req    (haz_req),
    .o_ret_valid  (ret_valid),
    .o_haz_rsp    (haz_rsp)
  );

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [7:0] bytes_of(input logic [2:0] off, input logic [1:0] sz);
    logic [7:0] m;
    for (int b = 0; b < 8; b++) begin
      m[b] = (b >= int'(off)) && (b < int'(off) + (1 << int'(sz)));
    end
    return m;
  endfunction

  function automatic logic load_after(input logic [4:0] a, input logic [4:0] b);
    logic [4:0] d;
    d = a - b;
    return (d >= 5'd1) && (d <= 5'd15);
  endfunction

  // Naturally aligned address in a small pool of four words
  function automatic logic [31:0] pool_addr(input logic [1:0] sz);
    logic [31:0] r;
    logic [2:0]  off;
    r = rand_bits(5);
    off = r[2:0] & ~(3'((1 << int'(sz)) - 1));
    return 32'h0000_1000 | {27'd0, r[4:3], 3'd0} | {29'd0, off};
  endfunction

  // --------------------
  // Cycle model
  // --------------------
  always @(posedge i_clk or negedge i_reset_n) begin : model_step
    logic       hv;
    logic [4:0] hid;
    logic       hit;
    int         e;
    if (!i_reset_n) begin
      for (int i = 0; i < 8; i++) begin
        m_valid[i] = 1'b0;
        m_dead[i]  = 1'b0;
        m_cmtd[i]  = 1'b0;
        m_state[i] = LDQ_IDLE;
      end
      m_in = 0;
      m_out = 0;
      exp_ret <= 1'b0;
      exp_hv[0] <= 1'b0;
      exp_hv[1] <= 1'b0;
    end else begin
      // Hazard scan from the oldest entry
      for (int p = 0; p < 2; p++) begin
        hv = 1'b0;
        hid = '0;
        for (int j = 0; j < 8; j++) begin
          e = (m_out + j) % 8;
          if (!hv && haz_req[p].valid && m_valid[e] && !m_dead[e] &&
              (m_state[e] == LDQ_DATA_OK || m_state[e] == LDQ_WAIT_RETIRE) &&
              load_after(m_id[e], haz_req[p].cmt_id) &&
              m_addr[e][31:3] == haz_req[p].paddr[31:3] &&
              (bytes_of(m_addr[e][2:0], m_size[e]) &
               bytes_of(haz_req[p].paddr[2:0], haz_req[p].size)) != 8'h00) begin
            hv = 1'b1;
            hid = m_id[e];
          end
        end
        exp_hv[p] <= hv;
        exp_hid[p] <= hid;
      end
      // Retire at the out pointer
      if (m_valid[m_out] && m_state[m_out] == LDQ_WAIT_RETIRE) begin
        m_valid[m_out] = 1'b0;
        m_state[m_out] = LDQ_IDLE;
        m_out = (m_out + 1) % 8;
        exp_ret <= 1'b1;
      end else begin
        exp_ret <= 1'b0;
      end
      for (int i = 0; i < 8; i++) begin
        if (!m_valid[i]) begin
          continue;
        end
        if (commit.valid && commit.flush) begin
          m_dead[i] = 1'b1;
          m_state[i] = LDQ_WAIT_RETIRE;
        end else if (!m_dead[i]) begin
          hit = commit.valid && !load_after(m_id[i], commit.cmt_id);
          if (hit) begin
            m_cmtd[i] = 1'b1;
          end
          case (m_state[i])
            LDQ_WAIT_EXEC: begin
              for (int p = 0; p < 2; p++) begin
                if (upd[p].valid && upd[p].cmt_id == m_id[i]) begin
                  m_addr[i] = upd[p].paddr;
                  m_size[i] = upd[p].size;
                  m_midx[i] = upd[p].miss_idx;
                  m_state[i] = upd[p].miss ? LDQ_MISS_WAIT : LDQ_DATA_OK;
                end
              end
            end
            LDQ_MISS_WAIT: begin
              if (resolve.valid && resolve.miss_idx == m_midx[i]) begin
                m_state[i] = LDQ_WAIT_EXEC;
              end
            end
            LDQ_DATA_OK: begin
              if (m_cmtd[i]) begin
                m_state[i] = LDQ_WAIT_RETIRE;
              end
            end
            default: begin
            end
          endcase
        end
      end
      // New loads land from the in pointer upward
      for (int k = 0; k < 2; k++) begin
        if (disp_valid[k]) begin
          e = (m_in + k) % 8;
          m_valid[e] = 1'b1;
          m_dead[e]  = 1'b0;
          m_cmtd[e]  = 1'b0;
          m_state[e] = LDQ_WAIT_EXEC;
          m_id[e]    = disp[k].cmt_id;
        end
      end
      m_in = (m_in + int'(disp_valid[0]) + int'(disp_valid[1])) % 8;
    end
  end

  // --------------------
  // Checks
  // --------------------
  ret_chk: assert property (@(posedge i_clk) ret_valid == exp_ret)
    else begin
      n_check_err++;
      $display("CHECK FAILED t=%0t o_ret_valid exp=%0b act=%0b", $time,
               $sampled(exp_ret), $sampled(ret_valid));
    end

  for (genvar p = 0; p < 2; p++) begin : g_haz_chk
    vld_chk: assert property (@(posedge i_clk) haz_rsp[p].valid == exp_hv[p])
      else begin
        n_check_err++;
        $display("CHECK FAILED t=%0t o_haz_rsp[%0d].valid exp=%0b act=%0b", $time, p,
                 $sampled(exp_hv[p]), $sampled(haz_rsp[p].valid));
      end
    id_chk: assert property (@(posedge i_clk) !exp_hv[p] || haz_rsp[p].cmt_id == exp_hid[p])
      else begin
        n_check_err++;
        $display("CHECK FAILED t=%0t o_haz_rsp[%0d].cmt_id exp=%0d act=%0d", $time, p,
                 $sampled(exp_hid[p]), $sampled(haz_rsp[p].cmt_id));
      end
  end

  // --------------------
  // Stimulus tasks
  // --------------------
  task automatic set_idle();
    disp_valid = '0;
    disp[0] = '0;
    disp[1] = '0;
    upd[0] = '0;
    upd[1] = '0;
    resolve = '0;
    commit = '0;
    haz_req[0] = '0;
    haz_req[1] = '0;
  endtask

  task automatic next_cycle();
    logic [31:0] r;
    @(negedge i_clk);
    if (ret_valid) begin
      credits++;
      n_ret++;
    end
    credit_chk: assert (credits >= 0 && credits <= 8)
      else begin
        n_other_err++;
        $display("Credit count out of range at %0t: %0d", $time, credits);
      end
    set_idle();
    for (int p = 0; p < 2 && probe_en; p++) begin
      r = rand_bits(8);
      haz_req[p].valid  = r[0];
      haz_req[p].cmt_id = next_id - {2'd0, r[3:1]} - 5'd1;
      haz_req[p].size   = r[5:4];
      haz_req[p].paddr  = pool_addr(r[5:4]);
    end
  endtask

  // Call after next_cycle; takes as many loads as credits allow
  task automatic dispatch_loads(input int n);
    for (int k = 0; k < n && k < 2 && credits > 0; k++) begin
      disp_valid[k] = 1'b1;
      disp[k].cmt_id = next_id;
      exec_q.push_back(next_id);
      next_id++;
      credits--;
      n_disp++;
    end
  endtask

  task automatic send_upd(input int p, input logic [4:0] id, input logic miss,
                          input logic [1:0] midx, input logic [31:0] addr, input logic [1:0] sz);
    upd[p].valid    = 1'b1;
    upd[p].cmt_id   = id;
    upd[p].paddr    = addr;
    upd[p].size     = sz;
    upd[p].miss     = miss;
    upd[p].miss_idx = midx;
  endtask

  task automatic wait_drain();
    int i;
    i = 0;
    while (credits != 8 && i < 200) begin
      next_cycle();
      i++;
    end
    drain_chk: assert (credits == 8)
      else begin
        n_other_err++;
        $display("Queue did not drain at %0t, credits %0d", $time, credits);
      end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin : main
    logic [31:0] r;
    logic [4:0]  id0;
    int          idx;
    int          ret_before;
    lfsr = 32'hd7062bc9;
    next_id = '0;
    probe_en = 1'b0;
    credits = 8;
    n_disp = 0;
    n_ret = 0;
    n_check_err = 0;
    n_other_err = 0;
    set_idle();
    wait (i_reset_n === 1'b1);
    repeat (4) next_cycle();

    // Random dual dispatch, shuffled hits, then one commit
    probe_en = 1'b1;
    repeat (6) begin
      exec_q.delete();
      while (credits > 0) begin
        next_cycle();
        r = rand_bits(1);
        dispatch_loads(int'(r[0]) + 1);
      end
      while (exec_q.size() > 0) begin
        next_cycle();
        for (int p = 0; p < 2 && exec_q.size() > 0; p++) begin
          r = rand_bits(5);
          idx = int'(r[3:0]) % exec_q.size();
          if (r[4]) begin
            send_upd(p, exec_q[idx], 1'b0, 2'd0, pool_addr(r[1:0]), r[1:0]);
            exec_q.delete(idx);
          end
        end
      end
      next_cycle();
      commit.valid = 1'b1;
      commit.cmt_id = next_id - 5'd1;
      wait_drain();
    end
    probe_en = 1'b0;

    // A missing head blocks younger committed loads
    exec_q.delete();
    next_cycle();
    dispatch_loads(2);
    next_cycle();
    dispatch_loads(1);
    next_cycle();
    send_upd(0, exec_q[0], 1'b1, 2'd2, 32'h0000_1100, 2'd2);
    send_upd(1, exec_q[1], 1'b0, 2'd0, 32'h0000_1108, 2'd3);
    next_cycle();
    send_upd(0, exec_q[2], 1'b0, 2'd0, 32'h0000_1110, 2'd1);
    next_cycle();
    commit.valid = 1'b1;
    commit.cmt_id = exec_q[2];
    repeat (12) next_cycle();
    miss_block_chk: assert (credits == 5)
      else begin
        n_other_err++;
        $display("Loads retired past a pending miss at %0t", $time);
      end
    resolve.valid = 1'b1;
    resolve.miss_idx = 2'd2;
    next_cycle();
    send_upd(1, exec_q[0], 1'b0, 2'd0, 32'h0000_1100, 2'd2);
    wait_drain();

    // Flush drains everything, executed or not
    exec_q.delete();
    ret_before = n_ret;
    next_cycle();
    dispatch_loads(2);
    next_cycle();
    dispatch_loads(2);
    next_cycle();
    dispatch_loads(1);
    send_upd(0, exec_q[0], 1'b0, 2'd0, 32'h0000_1200, 2'd3);
    send_upd(1, exec_q[1], 1'b1, 2'd1, 32'h0000_1208, 2'd3);
    next_cycle();
    commit.valid = 1'b1;
    commit.flush = 1'b1;
    commit.cmt_id = next_id - 5'd1;
    wait_drain();
    flush_chk: assert (n_ret - ret_before == 5)
      else begin
        n_other_err++;
        $display("Flush drained %0d loads instead of 5", n_ret - ret_before);
      end

    // Directed hazard probes
    exec_q.delete();
    next_cycle();
    dispatch_loads(2);
    next_cycle();
    dispatch_loads(2);
    id0 = exec_q[0];
    next_cycle();
    send_upd(0, exec_q[0], 1'b0, 2'd0, 32'h0000_2000, 2'd3);
    send_upd(1, exec_q[2], 1'b0, 2'd0, 32'h0000_2004, 2'd2);
    next_cycle();
    send_upd(0, exec_q[3], 1'b0, 2'd0, 32'h0000_2008, 2'd3);
    next_cycle();
    haz_req[0] = '{valid: 1'b1, cmt_id: id0, paddr: 32'h0000_2004, size: 2'd2};
    haz_req[1] = '{valid: 1'b1, cmt_id: id0 - 5'd1, paddr: 32'h0000_2000, size: 2'd0};
    next_cycle();
    haz_req[0] = '{valid: 1'b1, cmt_id: id0, paddr: 32'h0000_2000, size: 2'd1};
    haz_req[1] = '{valid: 1'b1, cmt_id: id0 - 5'd1, paddr: 32'h0000_2010, size: 2'd3};
    next_cycle();
    haz_req[0] = '{valid: 1'b1, cmt_id: id0 - 5'd1, paddr: 32'h0000_2002, size: 2'd1};
    send_upd(1, exec_q[1], 1'b0, 2'd0, 32'h0000_2002, 2'd1);
    next_cycle();
    commit.valid = 1'b1;
    commit.cmt_id = exec_q[3];
    wait_drain();

    // Credits all returned, pulses match dispatches
    repeat (3) next_cycle();
    total_chk: assert (credits == 8 && n_ret == n_disp)
      else begin
        n_other_err++;
        $display("Credit mismatch: credits %0d, dispatched %0d, retired %0d",
                 credits, n_disp, n_ret);
      end
    $display("Errors: check=%0d other=%0d", n_check_err, n_other_err);
    if (n_check_err == 0 && n_other_err == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #((TEST_CYCLES + 200) * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_clk_gen.sv
// Free-running clock and active-low reset; reset lets go on a falling edge after three rising edges
`default_nettype none
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter real CLK_PERIOD  = 8.0,
  parameter int  RESET_CYCLES = 3
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(CLK_PERIOD / 2.0) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- src/ldq_top.sv
// Load queue top; dispatch valids must be packed from slot 0 and never exceed the free credits
`default_nettype none
`timescale 1ns/100ps

`include "ldq_cfg.svh"

module ldq_top (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic [`LDQ_DISP_NUM-1:0]  i_disp_valid,
  input  ldq_pkg::ldq_disp_t        i_disp     [`LDQ_DISP_NUM],
  input  ldq_pkg::ldq_upd_t         i_upd      [`LDQ_PIPE_NUM],
  input  ldq_pkg::ldq_resolve_t     i_resolve,
  input  ldq_pkg::ldq_commit_t      i_commit,
  input  ldq_pkg::ldq_haz_req_t     i_haz_req  [`LDQ_PIPE_NUM],
  output logic                      o_ret_valid,
  output ldq_pkg::ldq_haz_rsp_t     o_haz_rsp  [`LDQ_PIPE_NUM]
);

  import ldq_pkg::*;

  logic [`LDQ_SIZE-1:0]  w_in_ptr_oh;
  logic [`LDQ_SIZE-1:0]  w_out_ptr_oh;
  logic [`LDQ_SIZE-1:0]  w_finish;
  logic [`LDQ_CNT_W-1:0] w_disp_num;
  logic [`LDQ_CNT_W-1:0] w_used_cnt;
  logic [`LDQ_SIZE-1:0]  w_slot_ptr_oh [`LDQ_DISP_NUM];
  ldq_entry_t            w_entries     [`LDQ_SIZE];
  logic                  w_ldq_busy;
  logic                  r_ret_valid;

  assign w_disp_num = `LDQ_CNT_W'($countones(i_disp_valid));
  assign w_ldq_busy = |w_used_cnt;

  ldq_ptr u_ptr (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_in_valid   (|i_disp_valid),
    .i_in_num     (w_disp_num),
    .i_out_valid  (|w_finish),
    .o_in_ptr_oh  (w_in_ptr_oh),
    .o_out_ptr_oh (w_out_ptr_oh),
    .o_used_cnt   (w_used_cnt)
  );

  // --------------------
  // Dispatch slotting
  // --------------------
  // Slot k lands k entries above the in pointer
  for (genvar k = 0; k < `LDQ_DISP_NUM; k++) begin : g_slot
    logic [2*`LDQ_SIZE-1:0] w_rot;

    assign w_rot            = {w_in_ptr_oh, w_in_ptr_oh} << k;
    assign w_slot_ptr_oh[k] = w_rot[2*`LDQ_SIZE-1:`LDQ_SIZE];
  end

  for (genvar l = 0; l < `LDQ_SIZE; l++) begin : g_entry
    logic [`LDQ_DISP_NUM-1:0] w_slot_hit;
    ldq_disp_t                w_disp_sel;
    ldq_upd_t                 w_upd_sel;

    always_comb begin
      w_disp_sel = '0;
      for (int k = 0; k < `LDQ_DISP_NUM; k++) begin
        w_slot_hit[k] = i_disp_valid[k] & w_slot_ptr_oh[k][l];
        if (w_slot_hit[k]) begin
          w_disp_sel = ldq_disp_t'(w_disp_sel | i_disp[k]);
        end
      end
    end

    // At most one pipe matches a live commit id
    always_comb begin
      w_upd_sel = '0;
      for (int p = 0; p < `LDQ_PIPE_NUM; p++) begin
        if (i_upd[p].valid && w_entries[l].valid && !w_entries[l].dead &&
            (i_upd[p].cmt_id == w_entries[l].cmt_id)) begin
          w_upd_sel = ldq_upd_t'(w_upd_sel | i_upd[p]);
        end
      end
    end

    ldq_entry u_entry (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_disp_load   (|w_slot_hit),
      .i_disp        (w_disp_sel),
      .i_upd         (w_upd_sel),
      .i_resolve     (i_resolve),
      .i_commit      (i_commit),
      .i_out_ptr_hit (w_out_ptr_oh[l]),
      .o_entry       (w_entries[l]),
      .o_finish      (w_finish[l])
    );
  end

  // --------------------
  // Store hazard checks
  // --------------------
  for (genvar p = 0; p < `LDQ_PIPE_NUM; p++) begin : g_haz
    ldq_haz_req_t w_req;

    // Nothing to scan in an empty queue
    always_comb begin
      w_req       = i_haz_req[p];
      w_req.valid = i_haz_req[p].valid & w_ldq_busy;
    end

    ldq_haz_check u_haz_check (
      .i_clk        (i_clk),
      .i_reset_n    (i_reset_n),
      .i_req        (w_req),
      .i_entries    (w_entries),
      .i_out_ptr_oh (w_out_ptr_oh),
      .o_rsp        (o_haz_rsp[p])
    );
  end

  // Retire pulse returns one credit to dispatch
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ret_valid <= 1'b0;
    end else begin
      r_ret_valid <= |w_finish;
    end
  end

  assign o_ret_valid = r_ret_valid;

endmodule

`default_nettype wire

//--- src/ldq_haz_check.sv
// Store-to-load hazard scan for one store pipe; response lands one cycle after the probe
`default_nettype none
`timescale 1ns/100ps

`include "ldq_cfg.svh"

module ldq_haz_check (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  ldq_pkg::ldq_haz_req_t i_req,
  input  ldq_pkg::ldq_entry_t   i_entries [`LDQ_SIZE],
  input  logic [`LDQ_SIZE-1:0]  i_out_ptr_oh,
  output ldq_pkg::ldq_haz_rsp_t o_rsp
);

  import ldq_pkg::*;

  logic [7:0]           w_st_mask;
  logic [`LDQ_SIZE-1:0] w_haz_vld;
  logic [`LDQ_SIZE-1:0] w_from_ptr;
  logic [`LDQ_SIZE-1:0] w_scan;
  logic [`LDQ_SIZE-1:0] w_sel_oh;
  cmt_id_t              w_sel_cmt_id;

  logic                 r_rsp_valid;
  cmt_id_t              r_rsp_cmt_id;

  assign w_st_mask = ldq_byte_mask(i_req.paddr[2:0], i_req.size);

  // --------------------
  // Per-entry match
  // --------------------
  for (genvar e = 0; e < `LDQ_SIZE; e++) begin : g_match
    logic w_has_data;
    logic w_same_word;
    logic w_overlap;

    assign w_has_data  = (i_entries[e].state == LDQ_DATA_OK) |
                         (i_entries[e].state == LDQ_WAIT_RETIRE);
    assign w_same_word = i_entries[e].paddr[`LDQ_PADDR_W-1:3] == i_req.paddr[`LDQ_PADDR_W-1:3];
    assign w_overlap   = |(ldq_byte_mask(i_entries[e].paddr[2:0], i_entries[e].size) & w_st_mask);

    assign w_haz_vld[e] = i_req.valid & i_entries[e].valid & ~i_entries[e].dead &
                          w_has_data & ldq_is_younger(i_entries[e].cmt_id, i_req.cmt_id) &
                          w_same_word & w_overlap;
  end

  // Oldest first from the out pointer upward, then wrap to the bottom
  assign w_from_ptr = w_haz_vld & ~(i_out_ptr_oh - 1'b1);
  assign w_scan     = (|w_from_ptr) ? w_from_ptr : w_haz_vld;
  assign w_sel_oh   = w_scan & (~w_scan + 1'b1);

  always_comb begin
    w_sel_cmt_id = '0;
    for (int e = 0; e < `LDQ_SIZE; e++) begin
      if (w_sel_oh[e]) begin
        w_sel_cmt_id = w_sel_cmt_id | i_entries[e].cmt_id;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rsp_valid <= 1'b0;
    end else begin
      r_rsp_valid <= |w_haz_vld;
    end
  end

  always_ff @(posedge i_clk) begin
    r_rsp_cmt_id <= w_sel_cmt_id;
  end

  assign o_rsp.valid  = r_rsp_valid;
  assign o_rsp.cmt_id = r_rsp_cmt_id;

endmodule

`default_nettype wire

//--- src/ldq_entry.sv
// One load queue entry; an update is taken only in LDQ_WAIT_EXEC, and a flush wins over any update that cycle
`default_nettype none
`timescale 1ns/100ps

`include "ldq_cfg.svh"

module ldq_entry (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_disp_load,
  input  ldq_pkg::ldq_disp_t    i_disp,
  input  ldq_pkg::ldq_upd_t     i_upd,
  input  ldq_pkg::ldq_resolve_t i_resolve,
  input  ldq_pkg::ldq_commit_t  i_commit,
  input  logic                  i_out_ptr_hit,
  output ldq_pkg::ldq_entry_t   o_entry,
  output logic                  o_finish
);

  import ldq_pkg::*;

  // Control state
  logic       r_valid;
  logic       r_dead;
  logic       r_committed;
  ldq_state_e r_state;

  // Load payload
  cmt_id_t    r_cmt_id;
  paddr_t     r_paddr;
  ldq_size_t  r_size;
  miss_idx_t  r_miss_idx;

  logic       w_flush;
  logic       w_cmt_hit;
  logic       w_upd_take;
  logic       w_resolve_hit;

  assign w_flush = i_commit.valid & i_commit.flush;

  // Committed id at or past ours means this load is architecturally done
  assign w_cmt_hit = i_commit.valid & ~i_commit.flush &
                     ~ldq_is_younger(r_cmt_id, i_commit.cmt_id);

  assign w_upd_take    = i_upd.valid & r_valid & ~r_dead & (r_state == LDQ_WAIT_EXEC);
  assign w_resolve_hit = i_resolve.valid & (i_resolve.miss_idx == r_miss_idx);

  assign o_finish = r_valid & (r_state == LDQ_WAIT_RETIRE) & i_out_ptr_hit;

  // --------------------
  // State machine
  // --------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid     <= 1'b0;
      r_dead      <= 1'b0;
      r_committed <= 1'b0;
      r_state     <= LDQ_IDLE;
    end else if (i_disp_load) begin
      r_valid     <= 1'b1;
      r_dead      <= 1'b0;
      r_committed <= 1'b0;
      r_state     <= LDQ_WAIT_EXEC;
    end else if (o_finish) begin
      r_valid     <= 1'b0;
      r_dead      <= 1'b0;
      r_committed <= 1'b0;
      r_state     <= LDQ_IDLE;
    end else if (r_valid & w_flush) begin
      // Whatever stage it was in, it just drains
      r_dead  <= 1'b1;
      r_state <= LDQ_WAIT_RETIRE;
    end else if (r_valid & ~r_dead) begin
      // Commit may arrive while still missing, so remember it
      if (w_cmt_hit) begin
        r_committed <= 1'b1;
      end
      case (r_state)
        LDQ_WAIT_EXEC: begin
          if (w_upd_take) begin
            r_state <= i_upd.miss ? LDQ_MISS_WAIT : LDQ_DATA_OK;
          end
        end
        LDQ_MISS_WAIT: begin
          // Back to waiting for the load pipe to replay
          if (w_resolve_hit) begin
            r_state <= LDQ_WAIT_EXEC;
          end
        end
        LDQ_DATA_OK: begin
          if (r_committed | w_cmt_hit) begin
            r_state <= LDQ_WAIT_RETIRE;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge i_clk) begin
    if (i_disp_load) begin
      r_cmt_id <= i_disp.cmt_id;
    end
    if (w_upd_take) begin
      r_paddr    <= i_upd.paddr;
      r_size     <= i_upd.size;
      r_miss_idx <= i_upd.miss_idx;
    end
  end

  always_comb begin
    o_entry.valid    = r_valid;
    o_entry.dead     = r_dead;
    o_entry.state    = r_state;
    o_entry.cmt_id   = r_cmt_id;
    o_entry.paddr    = r_paddr;
    o_entry.size     = r_size;
    o_entry.miss_idx = r_miss_idx;
  end

endmodule

`default_nettype wire

//--- src/ldq_ptr.sv
// In and out pointers for the load queue; caller keeps i_in_num within the free entries
`default_nettype none
`timescale 1ns/100ps

`include "ldq_cfg.svh"

module ldq_ptr (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_in_valid,
  input  logic [`LDQ_CNT_W-1:0] i_in_num,
  input  logic                  i_out_valid,
  output logic [`LDQ_SIZE-1:0]  o_in_ptr_oh,
  output logic [`LDQ_SIZE-1:0]  o_out_ptr_oh,
  output logic [`LDQ_CNT_W-1:0] o_used_cnt
);

  logic [`LDQ_SIZE-1:0]   r_in_ptr_oh;
  logic [`LDQ_SIZE-1:0]   r_out_ptr_oh;
  logic [`LDQ_CNT_W-1:0]  r_used_cnt;

  logic [2*`LDQ_SIZE-1:0] w_in_rot;
  logic [`LDQ_SIZE-1:0]   w_in_ptr_next;
  logic [`LDQ_SIZE-1:0]   w_out_ptr_next;
  logic [`LDQ_CNT_W-1:0]  w_add;
  logic [`LDQ_CNT_W-1:0]  w_sub;

  // Rotate left by i_in_num through a doubled copy
  assign w_in_rot      = {r_in_ptr_oh, r_in_ptr_oh} << i_in_num;
  assign w_in_ptr_next = w_in_rot[2*`LDQ_SIZE-1:`LDQ_SIZE];

  // Out pointer only ever moves by one
  assign w_out_ptr_next = {r_out_ptr_oh[`LDQ_SIZE-2:0], r_out_ptr_oh[`LDQ_SIZE-1]};

  assign w_add = i_in_valid  ? i_in_num : '0;
  assign w_sub = i_out_valid ? `LDQ_CNT_W'(1) : '0;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr_oh  <= `LDQ_SIZE'(1);
      r_out_ptr_oh <= `LDQ_SIZE'(1);
      r_used_cnt   <= '0;
    end else begin
      if (i_in_valid) begin
        r_in_ptr_oh <= w_in_ptr_next;
      end
      if (i_out_valid) begin
        r_out_ptr_oh <= w_out_ptr_next;
      end
      r_used_cnt <= r_used_cnt + w_add - w_sub;
    end
  end

  assign o_in_ptr_oh  = r_in_ptr_oh;
  assign o_out_ptr_oh = r_out_ptr_oh;
  assign o_used_cnt   = r_used_cnt;

endmodule

`default_nettype wire

//--- src/ldq_pkg.sv
// Load queue types; byte masks assume naturally aligned accesses inside one 8-byte word
`default_nettype none

`include "ldq_cfg.svh"

package ldq_pkg;

  typedef logic [`LDQ_CMT_W-1:0]      cmt_id_t;
  typedef logic [`LDQ_PADDR_W-1:0]    paddr_t;
  typedef logic [`LDQ_MISS_IDX_W-1:0] miss_idx_t;
  // 0..3 for 1, 2, 4, 8 bytes
  typedef logic [1:0]                 ldq_size_t;

  typedef enum logic [2:0] {
    LDQ_IDLE,
    LDQ_WAIT_EXEC,
    LDQ_MISS_WAIT,
    LDQ_DATA_OK,
    LDQ_WAIT_RETIRE
  } ldq_state_e;

  // --------------------
  // Interface payloads
  // --------------------
  typedef struct packed {
    cmt_id_t cmt_id;
  } ldq_disp_t;

  typedef struct packed {
    logic      valid;
    cmt_id_t   cmt_id;
    paddr_t    paddr;
    ldq_size_t size;
    logic      miss;
    miss_idx_t miss_idx;
  } ldq_upd_t;

  typedef struct packed {
    logic      valid;
    miss_idx_t miss_idx;
  } ldq_resolve_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    logic    flush;
  } ldq_commit_t;

  typedef struct packed {
    logic      valid;
    cmt_id_t   cmt_id;
    paddr_t    paddr;
    ldq_size_t size;
  } ldq_haz_req_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
  } ldq_haz_rsp_t;

  // What each entry exposes to the top and to the hazard scan
  typedef struct packed {
    logic       valid;
    logic       dead;
    ldq_state_e state;
    cmt_id_t    cmt_id;
    paddr_t     paddr;
    ldq_size_t  size;
    miss_idx_t  miss_idx;
  } ldq_entry_t;

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [7:0] ldq_byte_mask(input logic [2:0] offset, input ldq_size_t size);
    logic [7:0] base;
    case (size)
      2'd0:    base = 8'h01;
      2'd1:    base = 8'h03;
      2'd2:    base = 8'h0f;
      default: base = 8'hff;
    endcase
    return base << offset;
  endfunction

  // a younger than b when (a - b) mod 2^W falls in 1 .. 2^(W-1)-1
  function automatic logic ldq_is_younger(input cmt_id_t a, input cmt_id_t b);
    cmt_id_t diff;
    diff = a - b;
    return (diff != '0) && !diff[`LDQ_CMT_W-1];
  endfunction

endpackage

`default_nettype wire

//--- include/ldq_cfg.svh
// Sizes for the load queue; the pointer logic assumes LDQ_SIZE is a power of two and LDQ_CNT_W holds LDQ_SIZE
`ifndef LDQ_CFG_SVH
`define LDQ_CFG_SVH

// Queue depth and occupancy counter width
`define LDQ_SIZE        8
`define LDQ_CNT_W       4

// Loads accepted from dispatch per cycle
`define LDQ_DISP_NUM    2

// Load pipes and store pipes share one count
`define LDQ_PIPE_NUM    2

// Commit id with the top bit as the wrap bit
`define LDQ_CMT_W       5

// Physical address and miss unit slot index
`define LDQ_PADDR_W     32
`define LDQ_MISS_IDX_W  2

`endif
